// File: hdl/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// datapath widths
`define ID_WORD_W           32
`define ID_REG_ADDR_W       5

// primary opcodes, inst[31:26]
`define ID_OP_SPECIAL       6'b000000
`define ID_OP_ANDI          6'b001100
`define ID_OP_ORI           6'b001101
`define ID_OP_XORI          6'b001110
`define ID_OP_LUI           6'b001111
`define ID_OP_ADDI          6'b001000
`define ID_OP_ADDIU         6'b001001
`define ID_OP_SLTI          6'b001010
`define ID_OP_SLTIU         6'b001011

// function codes under SPECIAL, inst[5:0]
`define ID_FUNC_AND         6'b100100
`define ID_FUNC_OR          6'b100101
`define ID_FUNC_XOR         6'b100110
`define ID_FUNC_NOR         6'b100111
// sll with shamt zero is the nop encoding
`define ID_FUNC_SLL         6'b000000
`define ID_FUNC_SRL         6'b000010
`define ID_FUNC_SRA         6'b000011
`define ID_FUNC_SLLV        6'b000100
`define ID_FUNC_SRLV        6'b000110
`define ID_FUNC_SRAV        6'b000111
`define ID_FUNC_MOVN        6'b001011
`define ID_FUNC_MOVZ        6'b001010
`define ID_FUNC_ADD         6'b100000
`define ID_FUNC_ADDU        6'b100001
`define ID_FUNC_SUB         6'b100010
`define ID_FUNC_SUBU        6'b100011
`define ID_FUNC_SLT         6'b101010
`define ID_FUNC_SLTU        6'b101011

`endif

// File: hdl/id_itype_dec.sv
`timescale 1ns/1ps
`include "id_config.svh"

module id_itype_dec (
    input  id_pkg::inst_t     inst_i,
    output logic              hit_o,
    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::reg_addr_t waddr_o,
    output logic              wreg_o,
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o
);
    import id_pkg::*;

    logic [5:0]  op;
    logic [15:0] imm16;
    reg_addr_t   rs;
    reg_addr_t   rt;
    word_t       imm_zext;
    word_t       imm_sext;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign imm16 = inst_i[15:0];

    assign imm_zext = {{(`ID_WORD_W-16){1'b0}}, imm16};
    assign imm_sext = {{(`ID_WORD_W-16){imm16[15]}}, imm16};

    always_comb begin
        hit_o    = 1'b1;
        alusel_o = SEL_NOP;
        aluop_o  = OP_NOP;
        imm_o    = '0;

        case (op)
            `ID_OP_ANDI:  begin alusel_o = SEL_LOGIC; aluop_o = OP_AND;  imm_o = imm_zext; end
            `ID_OP_ORI:   begin alusel_o = SEL_LOGIC; aluop_o = OP_OR;   imm_o = imm_zext; end
            `ID_OP_XORI:  begin alusel_o = SEL_LOGIC; aluop_o = OP_XOR;  imm_o = imm_zext; end
            // or against rs, normally r0
            `ID_OP_LUI:   begin
                alusel_o = SEL_LOGIC;
                aluop_o  = OP_OR;
                imm_o    = {imm16, {(`ID_WORD_W-16){1'b0}}};
            end
            `ID_OP_ADDI:  begin alusel_o = SEL_ARITH; aluop_o = OP_ADD;  imm_o = imm_sext; end
            `ID_OP_ADDIU: begin alusel_o = SEL_ARITH; aluop_o = OP_ADDU; imm_o = imm_sext; end
            `ID_OP_SLTI:  begin alusel_o = SEL_ARITH; aluop_o = OP_SLT;  imm_o = imm_sext; end
            `ID_OP_SLTIU: begin alusel_o = SEL_ARITH; aluop_o = OP_SLTU; imm_o = imm_sext; end
            default:      hit_o = 1'b0;
        endcase
    end

    // every immediate form reads rs and writes rt
    assign wreg_o      = hit_o;
    assign waddr_o     = hit_o ? rt : '0;
    assign reg1_read_o = hit_o;
    assign reg1_addr_o = hit_o ? rs : '0;
    assign reg2_read_o = 1'b0;
    assign reg2_addr_o = '0;

endmodule

// File: hdl/id_operand_stage.sv
`timescale 1ns/1ps

module id_operand_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic              out_ready_i,
    output logic              out_valid_o,

    input  logic              r_hit_i,
    input  id_pkg::alu_sel_e  r_alusel_i,
    input  id_pkg::alu_op_e   r_aluop_i,
    input  id_pkg::reg_addr_t r_waddr_i,
    input  logic              r_wreg_i,
    input  logic              r_reg1_read_i,
    input  id_pkg::reg_addr_t r_reg1_addr_i,
    input  logic              r_reg2_read_i,
    input  id_pkg::reg_addr_t r_reg2_addr_i,
    input  id_pkg::word_t     r_imm_i,

    input  logic              i_hit_i,
    input  id_pkg::alu_sel_e  i_alusel_i,
    input  id_pkg::alu_op_e   i_aluop_i,
    input  id_pkg::reg_addr_t i_waddr_i,
    input  logic              i_wreg_i,
    input  logic              i_reg1_read_i,
    input  id_pkg::reg_addr_t i_reg1_addr_i,
    input  logic              i_reg2_read_i,
    input  id_pkg::reg_addr_t i_reg2_addr_i,
    input  id_pkg::word_t     i_imm_i,

    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,

    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::word_t     reg1_data_o,
    output id_pkg::word_t     reg2_data_o,
    output id_pkg::reg_addr_t waddr_o,
    output logic              wreg_o,
    output logic              illegal_o
);
    import id_pkg::*;

    alu_sel_e  sel_alusel;
    alu_op_e   sel_aluop;
    reg_addr_t sel_waddr;
    logic      sel_wreg;
    word_t     sel_imm;
    word_t     op1;
    word_t     op2;
    logic      move_ok;
    logic      wreg_nxt;
    logic      illegal;
    logic      accept;

    // the decoders never hit together
    always_comb begin
        illegal     = 1'b0;
        sel_alusel  = SEL_NOP;
        sel_aluop   = OP_NOP;
        sel_waddr   = '0;
        sel_wreg    = 1'b0;
        reg1_read_o = 1'b0;
        reg1_addr_o = '0;
        reg2_read_o = 1'b0;
        reg2_addr_o = '0;
        sel_imm     = '0;
        if (r_hit_i) begin
            sel_alusel  = r_alusel_i;
            sel_aluop   = r_aluop_i;
            sel_waddr   = r_waddr_i;
            sel_wreg    = r_wreg_i;
            reg1_read_o = r_reg1_read_i;
            reg1_addr_o = r_reg1_read_i ? r_reg1_addr_i : '0;
            reg2_read_o = r_reg2_read_i;
            reg2_addr_o = r_reg2_read_i ? r_reg2_addr_i : '0;
            sel_imm     = r_imm_i;
        end else if (i_hit_i) begin
            sel_alusel  = i_alusel_i;
            sel_aluop   = i_aluop_i;
            sel_waddr   = i_waddr_i;
            sel_wreg    = i_wreg_i;
            reg1_read_o = i_reg1_read_i;
            reg1_addr_o = i_reg1_read_i ? i_reg1_addr_i : '0;
            reg2_read_o = i_reg2_read_i;
            reg2_addr_o = i_reg2_read_i ? i_reg2_addr_i : '0;
            sel_imm     = i_imm_i;
        end else begin
            illegal = 1'b1;
        end
    end

    assign op1 = reg1_read_o ? reg1_data_i : '0;
    assign op2 = reg2_read_o ? reg2_data_i : sel_imm;

    // conditional moves depend on the rt value
    always_comb begin
        case (sel_aluop)
            OP_MOVN: move_ok = (reg2_data_i != '0);
            OP_MOVZ: move_ok = (reg2_data_i == '0);
            default: move_ok = 1'b1;
        endcase
    end

    assign wreg_nxt = sel_wreg & move_ok;

    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o <= 1'b0;
            alusel_o    <= SEL_NOP;
            aluop_o     <= OP_NOP;
            reg1_data_o <= '0;
            reg2_data_o <= '0;
            waddr_o     <= '0;
            wreg_o      <= 1'b0;
            illegal_o   <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
            alusel_o    <= sel_alusel;
            aluop_o     <= sel_aluop;
            reg1_data_o <= op1;
            reg2_data_o <= op2;
            waddr_o     <= sel_waddr;
            wreg_o      <= wreg_nxt;
            illegal_o   <= illegal;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

endmodule

// File: hdl/id_pkg.sv
`include "id_config.svh"

package id_pkg;

    // operand, immediate and result word
    typedef logic [`ID_WORD_W-1:0] word_t;

    // register file index
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [`ID_WORD_W-1:0] inst_t;

    // result class picked by the execute stage
    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_MOVE  = 3'd3,
        SEL_ARITH = 3'd4
    } alu_sel_e;

    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        OP_AND  = 5'd1,
        OP_OR   = 5'd2,
        OP_XOR  = 5'd3,
        OP_NOR  = 5'd4,
        OP_SLL  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_MOVN = 5'd8,
        OP_MOVZ = 5'd9,
        OP_ADD  = 5'd10,
        OP_ADDU = 5'd11,
        OP_SUB  = 5'd12,
        OP_SUBU = 5'd13,
        OP_SLT  = 5'd14,
        OP_SLTU = 5'd15
    } alu_op_e;

endpackage

// File: hdl/id_rtype_dec.sv
`timescale 1ns/1ps
`include "id_config.svh"

module id_rtype_dec (
    input  id_pkg::inst_t     inst_i,
    output logic              hit_o,
    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::reg_addr_t waddr_o,
    output logic              wreg_o,
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o
);
    import id_pkg::*;

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] shamt;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign shamt = inst_i[10:6];
    assign func  = inst_i[5:0];

    always_comb begin
        hit_o       = 1'b0;
        alusel_o    = SEL_NOP;
        aluop_o     = OP_NOP;
        waddr_o     = '0;
        wreg_o      = 1'b0;
        reg1_read_o = 1'b0;
        reg1_addr_o = '0;
        reg2_read_o = 1'b0;
        reg2_addr_o = '0;
        imm_o       = '0;

        if (op == `ID_OP_SPECIAL && shamt == 5'd0) begin
            hit_o = 1'b1;
            case (func)
                `ID_FUNC_AND:  begin alusel_o = SEL_LOGIC; aluop_o = OP_AND;  end
                `ID_FUNC_OR:   begin alusel_o = SEL_LOGIC; aluop_o = OP_OR;   end
                `ID_FUNC_XOR:  begin alusel_o = SEL_LOGIC; aluop_o = OP_XOR;  end
                `ID_FUNC_NOR:  begin alusel_o = SEL_LOGIC; aluop_o = OP_NOR;  end
                `ID_FUNC_SLLV: begin alusel_o = SEL_SHIFT; aluop_o = OP_SLL;  end
                `ID_FUNC_SRLV: begin alusel_o = SEL_SHIFT; aluop_o = OP_SRL;  end
                `ID_FUNC_SRAV: begin alusel_o = SEL_SHIFT; aluop_o = OP_SRA;  end
                `ID_FUNC_MOVN: begin alusel_o = SEL_MOVE;  aluop_o = OP_MOVN; end
                `ID_FUNC_MOVZ: begin alusel_o = SEL_MOVE;  aluop_o = OP_MOVZ; end
                `ID_FUNC_ADD:  begin alusel_o = SEL_ARITH; aluop_o = OP_ADD;  end
                `ID_FUNC_ADDU: begin alusel_o = SEL_ARITH; aluop_o = OP_ADDU; end
                `ID_FUNC_SUB:  begin alusel_o = SEL_ARITH; aluop_o = OP_SUB;  end
                `ID_FUNC_SUBU: begin alusel_o = SEL_ARITH; aluop_o = OP_SUBU; end
                `ID_FUNC_SLT:  begin alusel_o = SEL_ARITH; aluop_o = OP_SLT;  end
                `ID_FUNC_SLTU: begin alusel_o = SEL_ARITH; aluop_o = OP_SLTU; end
                // nop, nothing read or written
                `ID_FUNC_SLL:  ;
                default:       hit_o = 1'b0;
            endcase

            if (hit_o && alusel_o != SEL_NOP) begin
                wreg_o      = 1'b1;
                waddr_o     = rd;
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                // variable shifts take the value from rt, the amount from rs
                reg1_addr_o = (alusel_o == SEL_SHIFT) ? rt : rs;
                reg2_addr_o = (alusel_o == SEL_SHIFT) ? rs : rt;
            end
        end else if (op == `ID_OP_SPECIAL) begin
            hit_o = 1'b1;
            alusel_o = SEL_SHIFT;
            case (func)
                `ID_FUNC_SLL: aluop_o = OP_SLL;
                `ID_FUNC_SRL: aluop_o = OP_SRL;
                `ID_FUNC_SRA: aluop_o = OP_SRA;
                default: begin
                    hit_o    = 1'b0;
                    alusel_o = SEL_NOP;
                end
            endcase

            if (hit_o) begin
                wreg_o      = 1'b1;
                waddr_o     = rd;
                reg1_read_o = 1'b1;
                reg1_addr_o = rt;
                imm_o       = {{(`ID_WORD_W-5){1'b0}}, shamt};
            end
        end
    end

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              in_valid_i,
    input  id_pkg::inst_t     inst_i,
    output logic              in_ready_o,

    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,

    input  logic              out_ready_i,
    output logic              out_valid_o,
    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::word_t     reg1_data_o,
    output id_pkg::word_t     reg2_data_o,
    output id_pkg::reg_addr_t waddr_o,
    output logic              wreg_o,
    output logic              illegal_o
);
    import id_pkg::*;

    // R-type decoder fields
    logic      r_hit;
    alu_sel_e  r_alusel;
    alu_op_e   r_aluop;
    reg_addr_t r_waddr;
    logic      r_wreg;
    logic      r_reg1_read;
    reg_addr_t r_reg1_addr;
    logic      r_reg2_read;
    reg_addr_t r_reg2_addr;
    word_t     r_imm;

    // I-type decoder fields
    logic      i_hit;
    alu_sel_e  i_alusel;
    alu_op_e   i_aluop;
    reg_addr_t i_waddr;
    logic      i_wreg;
    logic      i_reg1_read;
    reg_addr_t i_reg1_addr;
    logic      i_reg2_read;
    reg_addr_t i_reg2_addr;
    word_t     i_imm;

    id_rtype_dec u_rtype_dec (
        .inst_i      (inst_i),
        .hit_o       (r_hit),
        .alusel_o    (r_alusel),
        .aluop_o     (r_aluop),
        .waddr_o     (r_waddr),
        .wreg_o      (r_wreg),
        .reg1_read_o (r_reg1_read),
        .reg1_addr_o (r_reg1_addr),
        .reg2_read_o (r_reg2_read),
        .reg2_addr_o (r_reg2_addr),
        .imm_o       (r_imm)
    );

    id_itype_dec u_itype_dec (
        .inst_i      (inst_i),
        .hit_o       (i_hit),
        .alusel_o    (i_alusel),
        .aluop_o     (i_aluop),
        .waddr_o     (i_waddr),
        .wreg_o      (i_wreg),
        .reg1_read_o (i_reg1_read),
        .reg1_addr_o (i_reg1_addr),
        .reg2_read_o (i_reg2_read),
        .reg2_addr_o (i_reg2_addr),
        .imm_o       (i_imm)
    );

    id_operand_stage u_operand_stage (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .out_ready_i   (out_ready_i),
        .out_valid_o   (out_valid_o),
        .r_hit_i       (r_hit),
        .r_alusel_i    (r_alusel),
        .r_aluop_i     (r_aluop),
        .r_waddr_i     (r_waddr),
        .r_wreg_i      (r_wreg),
        .r_reg1_read_i (r_reg1_read),
        .r_reg1_addr_i (r_reg1_addr),
        .r_reg2_read_i (r_reg2_read),
        .r_reg2_addr_i (r_reg2_addr),
        .r_imm_i       (r_imm),
        .i_hit_i       (i_hit),
        .i_alusel_i    (i_alusel),
        .i_aluop_i     (i_aluop),
        .i_waddr_i     (i_waddr),
        .i_wreg_i      (i_wreg),
        .i_reg1_read_i (i_reg1_read),
        .i_reg1_addr_i (i_reg1_addr),
        .i_reg2_read_i (i_reg2_read),
        .i_reg2_addr_i (i_reg2_addr),
        .i_imm_i       (i_imm),
        .reg1_data_i   (reg1_data_i),
        .reg2_data_i   (reg2_data_i),
        .reg1_read_o   (reg1_read_o),
        .reg1_addr_o   (reg1_addr_o),
        .reg2_read_o   (reg2_read_o),
        .reg2_addr_o   (reg2_addr_o),
        .alusel_o      (alusel_o),
        .aluop_o       (aluop_o),
        .reg1_data_o   (reg1_data_o),
        .reg2_data_o   (reg2_data_o),
        .waddr_o       (waddr_o),
        .wreg_o        (wreg_o),
        .illegal_o     (illegal_o)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

// File: tb/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_config.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int RST_CYCLES = 5;
    localparam int N_REG      = 40;
    localparam int N_SHIFT    = 24;
    localparam int N_IMM      = 40;
    localparam int N_MOVE     = 20;
    localparam int N_MIX      = 100;
    localparam int N_ILLEGAL  = 30;
    localparam int N_TOTAL    = 1 + N_REG + N_SHIFT + N_IMM + N_MOVE + N_MIX + N_ILLEGAL;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 20 * N_TOTAL;
    // alusel, aluop, operand 1, operand 2, waddr, wreg, illegal
    localparam int RES_W = 79;

    logic      clk;
    logic      arst_n_i;
    logic      in_valid_i;
    inst_t     inst_i;
    logic      in_ready_o;
    word_t     reg1_data_i;
    word_t     reg2_data_i;
    logic      reg1_read_o;
    reg_addr_t reg1_addr_o;
    logic      reg2_read_o;
    reg_addr_t reg2_addr_o;
    logic      out_ready_i;
    logic      out_valid_o;
    alu_sel_e  alusel_o;
    alu_op_e   aluop_o;
    word_t     reg1_data_o;
    word_t     reg2_data_o;
    reg_addr_t waddr_o;
    logic      wreg_o;
    logic      illegal_o;

    word_t            regs [0:31];
    logic [RES_W-1:0] exp_q [$];
    string            name_q [$];
    logic [RES_W-1:0] held;
    logic             held_valid;
    logic             stall_on;
    logic             gaps_on;

    tb_clk_gen #(.PERIOD_NS(8.0)) clk_gen (.clk_o(clk));

    id_stage DUT (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .inst_i      (inst_i),
        .in_ready_o  (in_ready_o),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .reg1_read_o (reg1_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_read_o (reg2_read_o),
        .reg2_addr_o (reg2_addr_o),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .alusel_o    (alusel_o),
        .aluop_o     (aluop_o),
        .reg1_data_o (reg1_data_o),
        .reg2_data_o (reg2_data_o),
        .waddr_o     (waddr_o),
        .wreg_o      (wreg_o),
        .illegal_o   (illegal_o)
    );

    // register file answers in the same cycle
    assign reg1_data_i = regs[reg1_addr_o];
    assign reg2_data_i = regs[reg2_addr_o];

    // reads holds read enable and address of port 1, then of port 2
    function automatic logic [RES_W-1:0] ref_decode(input inst_t inst,
                                                     output logic [11:0] reads);
        logic [5:0] op;
        logic [5:0] func;
        logic [4:0] shamt;
        logic [15:0] imm16;
        alu_sel_e   sel;
        alu_op_e    aop;
        logic       legal;
        logic       use1;
        logic       use2;
        logic       wr;
        reg_addr_t  a1;
        reg_addr_t  a2;
        reg_addr_t  wa;
        word_t      imm;
        word_t      d1;
        word_t      d2;
        op    = inst[31:26];
        shamt = inst[10:6];
        func  = inst[5:0];
        imm16 = inst[15:0];
        sel   = SEL_NOP;
        aop   = OP_NOP;
        legal = 1'b1;
        use1  = 1'b0;
        use2  = 1'b0;
        wr    = 1'b0;
        a1    = '0;
        a2    = '0;
        wa    = '0;
        imm   = '0;
        if (op == `ID_OP_SPECIAL && shamt == 5'd0) begin
            case (func)
                `ID_FUNC_AND:  begin sel = SEL_LOGIC; aop = OP_AND;  end
                `ID_FUNC_OR:   begin sel = SEL_LOGIC; aop = OP_OR;   end
                `ID_FUNC_XOR:  begin sel = SEL_LOGIC; aop = OP_XOR;  end
                `ID_FUNC_NOR:  begin sel = SEL_LOGIC; aop = OP_NOR;  end
                `ID_FUNC_SLLV: begin sel = SEL_SHIFT; aop = OP_SLL;  end
                `ID_FUNC_SRLV: begin sel = SEL_SHIFT; aop = OP_SRL;  end
                `ID_FUNC_SRAV: begin sel = SEL_SHIFT; aop = OP_SRA;  end
                `ID_FUNC_MOVN: begin sel = SEL_MOVE;  aop = OP_MOVN; end
                `ID_FUNC_MOVZ: begin sel = SEL_MOVE;  aop = OP_MOVZ; end
                `ID_FUNC_ADD:  begin sel = SEL_ARITH; aop = OP_ADD;  end
                `ID_FUNC_ADDU: begin sel = SEL_ARITH; aop = OP_ADDU; end
                `ID_FUNC_SUB:  begin sel = SEL_ARITH; aop = OP_SUB;  end
                `ID_FUNC_SUBU: begin sel = SEL_ARITH; aop = OP_SUBU; end
                `ID_FUNC_SLT:  begin sel = SEL_ARITH; aop = OP_SLT;  end
                `ID_FUNC_SLTU: begin sel = SEL_ARITH; aop = OP_SLTU; end
                `ID_FUNC_SLL:  ;
                default:       legal = 1'b0;
            endcase
            if (sel != SEL_NOP) begin
                use1 = 1'b1;
                use2 = 1'b1;
                wr   = 1'b1;
                wa   = inst[15:11];
                a1   = (sel == SEL_SHIFT) ? inst[20:16] : inst[25:21];
                a2   = (sel == SEL_SHIFT) ? inst[25:21] : inst[20:16];
            end
        end else if (op == `ID_OP_SPECIAL) begin
            case (func)
                `ID_FUNC_SLL: aop = OP_SLL;
                `ID_FUNC_SRL: aop = OP_SRL;
                `ID_FUNC_SRA: aop = OP_SRA;
                default:      legal = 1'b0;
            endcase
            if (legal) begin
                sel  = SEL_SHIFT;
                use1 = 1'b1;
                a1   = inst[20:16];
                wr   = 1'b1;
                wa   = inst[15:11];
                imm  = {27'd0, shamt};
            end
        end else begin
            case (op)
                `ID_OP_ANDI:  begin sel = SEL_LOGIC; aop = OP_AND;  imm = {16'd0, imm16}; end
                `ID_OP_ORI:   begin sel = SEL_LOGIC; aop = OP_OR;   imm = {16'd0, imm16}; end
                `ID_OP_XORI:  begin sel = SEL_LOGIC; aop = OP_XOR;  imm = {16'd0, imm16}; end
                `ID_OP_LUI:   begin sel = SEL_LOGIC; aop = OP_OR;   imm = {imm16, 16'd0}; end
                `ID_OP_ADDI:  begin sel = SEL_ARITH; aop = OP_ADD;  imm = 32'(signed'(imm16)); end
                `ID_OP_ADDIU: begin sel = SEL_ARITH; aop = OP_ADDU; imm = 32'(signed'(imm16)); end
                `ID_OP_SLTI:  begin sel = SEL_ARITH; aop = OP_SLT;  imm = 32'(signed'(imm16)); end
                `ID_OP_SLTIU: begin sel = SEL_ARITH; aop = OP_SLTU; imm = 32'(signed'(imm16)); end
                default:      legal = 1'b0;
            endcase
            if (legal) begin
                use1 = 1'b1;
                a1   = inst[25:21];
                wr   = 1'b1;
                wa   = inst[20:16];
            end
        end
        if (!legal) begin
            sel  = SEL_NOP;
            aop  = OP_NOP;
            use1 = 1'b0;
            use2 = 1'b0;
            wr   = 1'b0;
            wa   = '0;
            imm  = '0;
        end
        d1 = use1 ? regs[a1] : '0;
        d2 = use2 ? regs[a2] : imm;
        // conditional moves look at the rt value
        if (aop == OP_MOVN && regs[inst[20:16]] == '0)
            wr = 1'b0;
        if (aop == OP_MOVZ && regs[inst[20:16]] != '0)
            wr = 1'b0;
        reads = {use1, a1, use2, a2};
        return {sel, aop, d1, d2, wa, wr, ~legal};
    endfunction

    function automatic logic [RES_W-1:0] pack_outputs();
        return {alusel_o, aluop_o, reg1_data_o, reg2_data_o, waddr_o, wreg_o, illegal_o};
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(0, 31));
    endfunction

    function automatic logic [5:0] pick_reg_func();
        case ($urandom_range(0, 9))
            0:       return `ID_FUNC_AND;
            1:       return `ID_FUNC_OR;
            2:       return `ID_FUNC_XOR;
            3:       return `ID_FUNC_NOR;
            4:       return `ID_FUNC_ADD;
            5:       return `ID_FUNC_ADDU;
            6:       return `ID_FUNC_SUB;
            7:       return `ID_FUNC_SUBU;
            8:       return `ID_FUNC_SLT;
            default: return `ID_FUNC_SLTU;
        endcase
    endfunction

    function automatic logic [5:0] pick_shift(input logic variable);
        case ($urandom_range(0, 2))
            0:       return variable ? `ID_FUNC_SLLV : `ID_FUNC_SLL;
            1:       return variable ? `ID_FUNC_SRLV : `ID_FUNC_SRL;
            default: return variable ? `ID_FUNC_SRAV : `ID_FUNC_SRA;
        endcase
    endfunction

    function automatic logic [5:0] pick_imm_op();
        case ($urandom_range(0, 7))
            0:       return `ID_OP_ANDI;
            1:       return `ID_OP_ORI;
            2:       return `ID_OP_XORI;
            3:       return `ID_OP_LUI;
            4:       return `ID_OP_ADDI;
            5:       return `ID_OP_ADDIU;
            6:       return `ID_OP_SLTI;
            default: return `ID_OP_SLTIU;
        endcase
    endfunction

    function automatic inst_t rtype(input logic [5:0] func, input logic [4:0] shamt);
        return {`ID_OP_SPECIAL, rand_reg(), rand_reg(), rand_reg(), shamt, func};
    endfunction

    function automatic inst_t itype();
        return {pick_imm_op(), rand_reg(), rand_reg(), 16'($urandom())};
    endfunction

    function automatic inst_t move_inst(input reg_addr_t rt);
        logic [5:0] func;
        func = $urandom_range(0, 1) ? `ID_FUNC_MOVN : `ID_FUNC_MOVZ;
        return {`ID_OP_SPECIAL, rand_reg(), rt, rand_reg(), 5'd0, func};
    endfunction

    function automatic inst_t gen_illegal();
        inst_t inst;
        inst = $urandom();
        case ($urandom_range(0, 2))
            // primary opcodes above the immediate group
            0: inst[31:26] = 6'($urandom_range(16, 63));
            1: begin
                inst[31:26] = `ID_OP_SPECIAL;
                inst[10:6]  = 5'd0;
                // hi/lo moves and multiply/divide codes
                inst[5:0]   = $urandom_range(0, 1) ? 6'($urandom_range(16, 19))
                                                   : 6'($urandom_range(24, 27));
            end
            default: begin
                inst[31:26] = `ID_OP_SPECIAL;
                inst[10:6]  = 5'($urandom_range(1, 31));
                inst[5:0]   = pick_reg_func();
            end
        endcase
        return inst;
    endfunction

    function automatic inst_t gen_any();
        case ($urandom_range(0, 5))
            0:       return rtype(pick_reg_func(), 5'd0);
            1:       return rtype(pick_shift(1'b0), 5'($urandom_range(1, 31)));
            2:       return rtype(pick_shift(1'b1), 5'd0);
            3:       return itype();
            4:       return move_inst(rand_reg());
            default: return gen_illegal();
        endcase
    endfunction

    task automatic check(input string what, input logic [RES_W-1:0] expected,
                         input logic [RES_W-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    task automatic compare_result(input string name, input logic [RES_W-1:0] expected,
                                  input logic [RES_W-1:0] actual);
        check({name, " alusel"}, expected[78:76], actual[78:76]);
        check({name, " aluop"}, expected[75:71], actual[75:71]);
        check({name, " operand 1"}, expected[70:39], actual[70:39]);
        check({name, " operand 2"}, expected[38:7], actual[38:7]);
        check({name, " waddr"}, expected[6:2], actual[6:2]);
        check({name, " wreg"}, expected[1], actual[1]);
        check({name, " illegal"}, expected[0], actual[0]);
    endtask

    task automatic send(input inst_t inst, input string name);
        logic [RES_W-1:0] expect_vec;
        logic [11:0]      expect_rd;
        @(negedge clk);
        while (gaps_on && $urandom_range(0, 3) == 0) begin
            in_valid_i = 1'b0;
            @(negedge clk);
        end
        in_valid_i = 1'b1;
        inst_i     = inst;
        expect_vec = ref_decode(inst, expect_rd);
        @(posedge clk);
        while (!in_ready_o)
            @(posedge clk);
        check({name, " read ports"}, expect_rd,
              {reg1_read_o, reg1_addr_o, reg2_read_o, reg2_addr_o});
        exp_q.push_back(expect_vec);
        name_q.push_back(name);
    endtask

    // back-pressure source
    initial begin : ready_proc
        out_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            out_ready_i = stall_on ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    initial begin : compare_proc
        logic [RES_W-1:0] actual;
        held_valid = 1'b0;
        forever begin
            @(posedge clk);
            actual = pack_outputs();
            if (arst_n_i && out_valid_o) begin
                if (held_valid)
                    check("stall hold", held, actual);
                if (!out_ready_i) begin
                    check("stall in_ready", 1'b0, in_ready_o);
                    held       = actual;
                    held_valid = 1'b1;
                end else if (exp_q.size() == 0) begin
                    $display("error: output transfer with no instruction outstanding");
                    $display("TESTBENCH FAILED");
                    $fatal(1, "unexpected output transfer");
                end else begin
                    compare_result(name_q.pop_front(), exp_q.pop_front(), actual);
                    held_valid = 1'b0;
                end
            end else begin
                held_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog_proc
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_proc
        void'($urandom(32469));
        arst_n_i   = 1'b0;
        in_valid_i = 1'b0;
        inst_i     = '0;
        stall_on   = 1'b0;
        gaps_on    = 1'b0;
        regs[0]    = '0;
        for (int k = 1; k < 32; k++)
            regs[k] = $urandom();
        // second zero entry for movz
        regs[7] = '0;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        check("reset out_valid", 1'b0, out_valid_o);
        check("reset wreg", 1'b0, wreg_o);
        check("reset in_ready", 1'b1, in_ready_o);
        check("reset results", '0, pack_outputs());

        send(rtype(`ID_FUNC_ADD, 5'd0), "latency");
        @(negedge clk);
        in_valid_i = 1'b0;
        check("latency out_valid", 1'b1, out_valid_o);

        for (int i = 0; i < N_REG; i++)
            send(rtype(pick_reg_func(), 5'd0), "register op");

        for (int i = 0; i < 10; i++)
            send(rtype(pick_shift(1'b0), 5'($urandom_range(1, 31))), "shamt shift");
        for (int i = 0; i < 10; i++)
            send(rtype(pick_shift(1'b1), 5'd0), "variable shift");
        send(32'h0000_0000, "nop");
        for (int i = 0; i < 3; i++)
            send(rtype(`ID_FUNC_SLL, 5'd0), "sll zero shamt");

        for (int i = 0; i < N_IMM; i++)
            send(itype(), "immediate op");

        for (int i = 0; i < N_MOVE; i++)
            send(move_inst((i % 3 == 0) ? 5'd0 : (i % 3 == 1) ? 5'd7 : rand_reg()),
                 "conditional move");

        stall_on = 1'b1;
        gaps_on  = 1'b1;
        for (int i = 0; i < N_MIX; i++)
            send(gen_any(), "mixed with stalls");
        for (int i = 0; i < N_ILLEGAL; i++)
            send(gen_illegal(), "illegal encoding");

        @(negedge clk);
        in_valid_i = 1'b0;
        gaps_on    = 1'b0;
        stall_on   = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);

        // last result handed on, nothing new accepted
        if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
            $display("error: stage not idle after the last result was taken");
            $display("TESTBENCH FAILED");
            $fatal(1, "stage not idle at end");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/id_pkg.sv
hdl/id_rtype_dec.sv
hdl/id_itype_dec.sv
hdl/id_operand_stage.sv
hdl/id_stage.sv
tb/tb_clk_gen.sv
tb/tb_id_stage.sv
